/* logic/commit_csr_path.sv */
/*
 * CSR side of the commit stage.
 * Presents the head CSR operation, merges FPU flags of both ports into
 * one fflags write and marks the FP state dirty.
 */
`timescale 1ns/100ps
`default_nettype none

module commit_csr_path import commit_pkg::*; (
  input  wire scoreboard_entry_t instr0_i,
  input  wire scoreboard_entry_t instr1_i,
  input  wire logic [1:0]        drop_i,
  output fu_op_t                 csr_op_o,
  output logic [XLEN-1:0]        csr_wdata_o,
  output logic                   csr_write_fflags_o,
  output logic                   dirty_fp_state_o,
  commit_grant_if.csr_mp         grant_if
);

  logic                   csr_head;
  logic                   flags0_en;
  logic                   flags1_en;
  logic [FFLAGS_BITS-1:0] flags0;
  logic [FFLAGS_BITS-1:0] flags1;

  // head csr is shown even while held
  // the csr file needs the op to raise its own fault
  assign csr_head = instr0_i.valid && !instr0_i.ex.valid && instr0_i.fu == CSR;

  // ------------------------------
  // fflags merge
  // ------------------------------
  assign flags0_en = grant_if.ack0 && !drop_i[0] && instr0_i.fu == FPU;
  assign flags1_en = grant_if.ack1 && !drop_i[1] && instr1_i.fu == FPU;

  // fpu entries reuse the cause word for their accrued flags
  assign flags0 = flags0_en ? instr0_i.ex.cause.fp.flags : '0;
  assign flags1 = flags1_en ? instr1_i.ex.cause.fp.flags : '0;

  always_comb begin : csr_drive
    csr_op_o           = ADD;
    csr_wdata_o        = '0;
    csr_write_fflags_o = 1'b0;
    if (csr_head) begin
      csr_op_o    = instr0_i.op;
      csr_wdata_o = instr0_i.result;
    end else if (flags0_en || flags1_en) begin
      // one write carries both ports
      csr_wdata_o        = {{(XLEN-FFLAGS_BITS){1'b0}}, flags0 | flags1};
      csr_write_fflags_o = 1'b1;
    end
  end

  // any retiring fp work dirties the fs field
  assign dirty_fp_state_o = (grant_if.ack0 && (instr0_i.fu == FPU || grant_if.fpr0))
                            || (grant_if.ack1 && (instr1_i.fu == FPU || grant_if.fpr1));

endmodule

`default_nettype wire

/* logic/commit_exception_sel.sv */
/*
 * Trap selection for the scoreboard head.
 * Earlier pipeline exceptions win over a fault raised by the CSR file.
 */
`timescale 1ns/100ps
`default_nettype none

module commit_exception_sel import commit_pkg::*; (
  input  wire logic              halt_i,
  input  wire scoreboard_entry_t instr0_i,
  input  wire logic              drop0_i,
  input  wire exception_t        csr_exception_i,
  output exception_t             exception_o
);

  always_comb begin : trap_select
    exception_o = '0;

    // only a live head can trap
    if (instr0_i.valid && !drop0_i) begin
      // csr fault
      // the entry tval still holds the instruction bits from decode
      if (csr_exception_i.valid) begin
        exception_o      = csr_exception_i;
        exception_o.tval = instr0_i.ex.tval;
      end
      // earlier faults such as fetch page faults take precedence
      if (instr0_i.ex.valid) begin
        exception_o = instr0_i.ex;
      end
    end

    // halted core takes no trap
    if (halt_i) begin
      exception_o.valid = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* logic/commit_grant_if.sv */
/*
 * Per-port acknowledge and FP-write grant levels.
 * Port 0 drives its pair, port 1 chains off ack0, the CSR path reads all.
 */
`timescale 1ns/100ps
`default_nettype none

interface commit_grant_if ();

  // port 0 acknowledge and undropped fpr write
  logic ack0;
  logic fpr0;
  // port 1 acknowledge and undropped fpr write
  logic ack1;
  logic fpr1;

  modport port0_mp (output ack0, output fpr0);

  // port 1 may only retire behind port 0
  modport port1_mp (input ack0, output ack1, output fpr1);

  modport csr_mp (input ack0, input fpr0, input ack1, input fpr1);

endinterface

`default_nettype wire

/* logic/commit_pkg.sv */
/*
 * Shared types for the dual-port commit stage.
 * Holds the widths, unit and operation encodings, the scoreboard entry
 * layout and the small decode helpers used by every commit block.
 */
`default_nettype none

package commit_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int unsigned XLEN          = 32;
  localparam int unsigned VLEN          = 32;
  localparam int unsigned REG_ADDR_BITS = 5;
  localparam int unsigned TRANS_ID_BITS = 3;
  localparam int unsigned FFLAGS_BITS   = 5;

  // functional unit that executed the entry
  typedef enum logic [3:0] {
    NONE,
    LOAD,
    STORE,
    ALU,
    CTRL_FLOW,
    MULT,
    CSR,
    FPU
  } fu_t;

  // operation subset seen at commit
  // ADD doubles as the CSR no-op
  typedef enum logic [4:0] {
    ADD,
    CSR_RW,
    CSR_RS,
    FENCE,
    FENCE_I,
    SFENCE_VMA,
    AMO_SWAP,
    AMO_ADD,
    FADD,
    FLW,
    FCVT_W,
    LW
  } fu_op_t;

  // ------------------------------
  // exception word
  // ------------------------------
  // trap entries use the full cause number
  // fpu entries carry accrued flags in the low bits instead
  typedef union packed {
    logic [XLEN-1:0] num;
    struct packed {
      logic [XLEN-FFLAGS_BITS-1:0] pad;
      logic [FFLAGS_BITS-1:0]      flags;
    } fp;
  } ex_cause_u;

  typedef struct packed {
    logic            valid;
    ex_cause_u       cause;
    logic [XLEN-1:0] tval;
  } exception_t;

  // one scoreboard slot as presented by the issue side
  typedef struct packed {
    logic [VLEN-1:0]          pc;
    logic [TRANS_ID_BITS-1:0] trans_id;
    fu_t                      fu;
    fu_op_t                   op;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [XLEN-1:0]          result;
    logic                     valid;
    exception_t               ex;
  } scoreboard_entry_t;

  // ------------------------------
  // decode helpers
  // ------------------------------
  function automatic logic is_amo(input fu_op_t op);
    return op inside {AMO_SWAP, AMO_ADD};
  endfunction

  // fcvt.w lands in the integer file so it is not listed
  function automatic logic is_rd_fpr(input fu_op_t op);
    return op inside {FADD, FLW};
  endfunction

endpackage

`default_nettype wire

/* logic/commit_port0_ctrl.sv */
/*
 * Commit decision for the scoreboard head.
 * Drives the port 0 acknowledge, register writeback and the LSU, CSR,
 * fence and AMO strobes, holding the entry while a side unit is busy.
 */
`timescale 1ns/100ps
`default_nettype none

module commit_port0_ctrl import commit_pkg::*; (
  input  wire logic              halt_i,
  input  wire scoreboard_entry_t instr0_i,
  input  wire logic              drop0_i,
  input  wire logic              commit_lsu_ready_i,
  input  wire logic              no_st_pending_i,
  input  wire logic              amo_ack_i,
  input  wire logic [XLEN-1:0]   amo_result_i,
  input  wire logic [XLEN-1:0]   csr_rdata_i,
  input  wire logic              csr_exception_valid_i,
  output logic                   we_gpr0_o,
  output logic [XLEN-1:0]        wdata0_o,
  output logic                   commit_lsu_o,
  output logic                   commit_csr_o,
  output logic                   fence_o,
  output logic                   fence_i_o,
  output logic                   sfence_vma_o,
  output logic                   flush_commit_o,
  output logic                   amo_valid_commit_o,
  commit_grant_if.port0_mp       grant_if
);

  logic instr0_is_amo;
  // acknowledge before it goes onto the interface
  logic ack;
  // undropped write request, still subject to ack
  logic wr_gpr;
  logic wr_fpr;

  assign instr0_is_amo = is_amo(instr0_i.op);

  // ------------------------------
  // commit decision
  // ------------------------------
  always_comb begin : head_commit
    ack                = 1'b0;
    wr_gpr             = 1'b0;
    wr_fpr             = 1'b0;
    commit_lsu_o       = 1'b0;
    commit_csr_o       = 1'b0;
    fence_o            = 1'b0;
    fence_i_o          = 1'b0;
    sfence_vma_o       = 1'b0;
    flush_commit_o     = 1'b0;
    amo_valid_commit_o = 1'b0;
    // amo data arrives from the cache, everything else from the entry
    wdata0_o = (instr0_is_amo && amo_ack_i) ? amo_result_i : instr0_i.result;

    // nothing retires while the controller asks for a halt
    if (instr0_i.valid && !halt_i) begin
      if (instr0_i.ex.valid) begin
        // faulting entry only leaves when it is being dropped
        ack = drop0_i;
      end else begin
        ack = 1'b1;

        // pick the destination file
        if (!drop0_i) begin
          if (is_rd_fpr(instr0_i.op)) begin
            wr_fpr = 1'b1;
          end else begin
            wr_gpr = 1'b1;
          end
        end

        // store goes to the lsu commit buffer
        // amos also sit in the store unit but take their own path below
        if (instr0_i.fu == STORE && !instr0_is_amo) begin
          commit_lsu_o = commit_lsu_ready_i;
          ack          = commit_lsu_ready_i;
        end

        // csr instruction
        // stall while the csr file reports a fault, the trap path takes over
        if (instr0_i.fu == CSR && !drop0_i) begin
          if (csr_exception_valid_i) begin
            ack = 1'b0;
          end else begin
            commit_csr_o = 1'b1;
            wdata0_o     = csr_rdata_i;
          end
        end

        // ------------------------------
        // fences
        // ------------------------------
        // all three wait for the store buffer to drain
        if (instr0_i.op == FENCE && !drop0_i) begin
          fence_o = no_st_pending_i;
          ack     = no_st_pending_i;
        end
        if (instr0_i.op == FENCE_I && !drop0_i) begin
          fence_i_o = no_st_pending_i;
          ack       = no_st_pending_i;
        end
        // tlb flush is idempotent so replay after a trap is harmless
        if (instr0_i.op == SFENCE_VMA && !drop0_i) begin
          sfence_vma_o = no_st_pending_i;
          ack          = no_st_pending_i;
        end

        // amo holds until the response then flushes the pipeline
        if (instr0_is_amo) begin
          amo_valid_commit_o = 1'b1;
          flush_commit_o     = amo_ack_i;
          ack                = amo_ack_i;
        end
      end
    end
  end

  // writes only happen on the cycle the entry leaves
  assign we_gpr0_o     = wr_gpr & ack;
  assign grant_if.fpr0 = wr_fpr & ack;
  assign grant_if.ack0 = ack;

endmodule

`default_nettype wire

/* logic/commit_port1_ctrl.sv */
/*
 * Second commit port.
 * Retires a simple instruction alongside the head when port 0 commits
 * something that cannot redirect or serialize the pipeline.
 */
`timescale 1ns/100ps
`default_nettype none

module commit_port1_ctrl import commit_pkg::*; (
  input  wire logic              halt_i,
  input  wire logic              single_step_i,
  input  wire scoreboard_entry_t instr0_i,
  input  wire scoreboard_entry_t instr1_i,
  input  wire logic              drop1_i,
  output logic                   we_gpr1_o,
  output logic [XLEN-1:0]        wdata1_o,
  commit_grant_if.port1_mp       grant_if
);

  // head does not block a pairing
  logic head_ok;
  // second entry is of a kind that may pair
  logic instr1_ok;
  logic ack;

  // csr and amo heads serialize so nothing retires beside them
  assign head_ok = grant_if.ack0 && !halt_i && !single_step_i
                   && instr0_i.fu != CSR && !is_amo(instr0_i.op);

  // faulting entries must wait to become the head
  assign instr1_ok = instr1_i.valid && !instr1_i.ex.valid
                     && (instr1_i.fu inside {ALU, LOAD, CTRL_FLOW, MULT, FPU});

  assign ack = head_ok && instr1_ok;

  // ------------------------------
  // writeback
  // ------------------------------
  assign we_gpr1_o     = ack && !drop1_i && !is_rd_fpr(instr1_i.op);
  assign grant_if.fpr1 = ack && !drop1_i && is_rd_fpr(instr1_i.op);
  assign grant_if.ack1 = ack;

  // data path needs no qualification
  assign wdata1_o = instr1_i.result;

endmodule

`default_nettype wire

/* logic/commit_stage_top.sv */
/*
 * Dual-port commit stage top.
 * Purely combinational retire logic between the scoreboard head and the
 * register files, LSU, CSR file and controller.
 */
`timescale 1ns/100ps
`default_nettype none

module commit_stage_top import commit_pkg::*; (
  input  wire logic                          halt_i,
  input  wire logic                          single_step_i,
  input  wire scoreboard_entry_t             commit_instr0_i,
  input  wire scoreboard_entry_t             commit_instr1_i,
  input  wire logic [1:0]                    commit_drop_i,
  input  wire logic                          amo_ack_i,
  input  wire logic [XLEN-1:0]               amo_result_i,
  input  wire logic [XLEN-1:0]               csr_rdata_i,
  input  wire exception_t                    csr_exception_i,
  input  wire logic                          commit_lsu_ready_i,
  input  wire logic                          no_st_pending_i,
  output logic [1:0]                         commit_ack_o,
  output logic [1:0][REG_ADDR_BITS-1:0]      waddr_o,
  output logic [1:0][XLEN-1:0]               wdata_o,
  output logic [1:0]                         we_gpr_o,
  output logic [1:0]                         we_fpr_o,
  output logic [VLEN-1:0]                    pc_o,
  output logic [TRANS_ID_BITS-1:0]           commit_tran_id_o,
  output fu_op_t                             csr_op_o,
  output logic [XLEN-1:0]                    csr_wdata_o,
  output logic                               csr_write_fflags_o,
  output logic                               dirty_fp_state_o,
  output exception_t                         exception_o,
  output logic                               commit_lsu_o,
  output logic                               commit_csr_o,
  output logic                               amo_valid_commit_o,
  output logic                               fence_o,
  output logic                               fence_i_o,
  output logic                               sfence_vma_o,
  output logic                               flush_commit_o
);

  commit_grant_if u_grant ();

  // ------------------------------
  // field wiring
  // ------------------------------
  assign waddr_o[0]       = commit_instr0_i.rd;
  assign waddr_o[1]       = commit_instr1_i.rd;
  assign pc_o             = commit_instr0_i.pc;
  assign commit_tran_id_o = commit_instr0_i.trans_id;

  assign commit_ack_o = {u_grant.ack1, u_grant.ack0};
  assign we_fpr_o     = {u_grant.fpr1, u_grant.fpr0};

  commit_port0_ctrl u_port0 (
    .halt_i                (halt_i),
    .instr0_i              (commit_instr0_i),
    .drop0_i               (commit_drop_i[0]),
    .commit_lsu_ready_i    (commit_lsu_ready_i),
    .no_st_pending_i       (no_st_pending_i),
    .amo_ack_i             (amo_ack_i),
    .amo_result_i          (amo_result_i),
    .csr_rdata_i           (csr_rdata_i),
    .csr_exception_valid_i (csr_exception_i.valid),
    .we_gpr0_o             (we_gpr_o[0]),
    .wdata0_o              (wdata_o[0]),
    .commit_lsu_o          (commit_lsu_o),
    .commit_csr_o          (commit_csr_o),
    .fence_o               (fence_o),
    .fence_i_o             (fence_i_o),
    .sfence_vma_o          (sfence_vma_o),
    .flush_commit_o        (flush_commit_o),
    .amo_valid_commit_o    (amo_valid_commit_o),
    .grant_if              (u_grant.port0_mp)
  );

  // second port chains off the head acknowledge
  commit_port1_ctrl u_port1 (
    .halt_i        (halt_i),
    .single_step_i (single_step_i),
    .instr0_i      (commit_instr0_i),
    .instr1_i      (commit_instr1_i),
    .drop1_i       (commit_drop_i[1]),
    .we_gpr1_o     (we_gpr_o[1]),
    .wdata1_o      (wdata_o[1]),
    .grant_if      (u_grant.port1_mp)
  );

  commit_csr_path u_csr (
    .instr0_i           (commit_instr0_i),
    .instr1_i           (commit_instr1_i),
    .drop_i             (commit_drop_i),
    .csr_op_o           (csr_op_o),
    .csr_wdata_o        (csr_wdata_o),
    .csr_write_fflags_o (csr_write_fflags_o),
    .dirty_fp_state_o   (dirty_fp_state_o),
    .grant_if           (u_grant.csr_mp)
  );

  commit_exception_sel u_exc (
    .halt_i          (halt_i),
    .instr0_i        (commit_instr0_i),
    .drop0_i         (commit_drop_i[0]),
    .csr_exception_i (csr_exception_i),
    .exception_o     (exception_o)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the commit stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
  --top-module tb_commit_stage -o sim_commit

./obj_dir/sim_commit > sim.log
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
exit 0

/* sim/tb_commit_checks.svh */
/*
 * Stimulus and checks for the commit stage testbench.
 * Included inside tb_commit_stage with one task per behavior and the compare helpers.
 */

// ------------------------------
// compare helpers
// ------------------------------
task automatic expect_word(input string name, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  assert (got === exp) else begin
    $display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    errors++;
  end
endtask

task automatic expect_bit(input string name, input logic got, input logic exp);
  expect_word(name, 32'(got), 32'(exp));
endtask

// ------------------------------
// behaviors
// ------------------------------
task automatic dual_alu_commit();
  scoreboard_entry_t e0;
  scoreboard_entry_t e1;
  e0 = make_entry(ALU, ADD);
  e1 = make_entry(ALU, ADD);
  @(negedge clk_i);
  commit_instr0_i = e0;
  commit_instr1_i = e1;
  #1;
  expect_word("commit_ack_o", 32'(commit_ack_o), 32'h3);
  expect_word("we_gpr_o", 32'(we_gpr_o), 32'h3);
  expect_word("wdata_o[0]", wdata_o[0], e0.result);
  expect_word("wdata_o[1]", wdata_o[1], e1.result);
  expect_word("waddr_o[0]", 32'(waddr_o[0]), 32'(e0.rd));
  expect_word("waddr_o[1]", 32'(waddr_o[1]), 32'(e1.rd));
  // head pc and id go straight out
  expect_word("pc_o", pc_o, e0.pc);
  expect_word("commit_tran_id_o", 32'(commit_tran_id_o), 32'(e0.trans_id));
  // single step retires the head only
  @(negedge clk_i);
  single_step_i = 1'b1;
  #1;
  expect_word("commit_ack_o", 32'(commit_ack_o), 32'h1);
  // halt stops both ports
  @(negedge clk_i);
  single_step_i = 1'b0;
  halt_i        = 1'b1;
  #1;
  expect_word("commit_ack_o", 32'(commit_ack_o), 32'h0);
  halt_i = 1'b0;
endtask

task automatic store_backpressure();
  @(negedge clk_i);
  commit_instr0_i = make_entry(STORE, ADD);
  commit_instr1_i = make_entry(STORE, ADD);
  commit_lsu_ready_i = 1'b0;
  #1;
  expect_bit("commit_ack_o[0]", commit_ack_o[0], 1'b0);
  expect_bit("commit_lsu_o", commit_lsu_o, 1'b0);
  @(negedge clk_i);
  commit_lsu_ready_i = 1'b1;
  #1;
  expect_bit("commit_ack_o[0]", commit_ack_o[0], 1'b1);
  expect_bit("commit_lsu_o", commit_lsu_o, 1'b1);
  // stores never pair on port 1
  expect_bit("commit_ack_o[1]", commit_ack_o[1], 1'b0);
endtask

task automatic fence_drain();
  fu_op_t ops [3] = '{FENCE, FENCE_I, SFENCE_VMA};
  for (int i = 0; i < 3; i++) begin
    @(negedge clk_i);
    commit_instr0_i = make_entry(NONE, ops[i]);
    no_st_pending_i = 1'b0;
    #1;
    expect_bit("commit_ack_o[0]", commit_ack_o[0], 1'b0);
    expect_word("fence strobes", 32'({fence_o, fence_i_o, sfence_vma_o}), 32'h0);
    // store buffer drained so only the matching strobe fires
    @(negedge clk_i);
    no_st_pending_i = 1'b1;
    #1;
    expect_bit("commit_ack_o[0]", commit_ack_o[0], 1'b1);
    expect_word("fence strobes", 32'({fence_o, fence_i_o, sfence_vma_o}), 32'(3'b100 >> i));
  end
endtask

task automatic csr_commit_trap();
  scoreboard_entry_t e0;
  e0 = make_entry(CSR, CSR_RW);
  e0.ex.tval = rand_bits(32);
  @(negedge clk_i);
  commit_instr0_i = e0;
  csr_rdata_i     = rand_bits(32);
  #1;
  expect_bit("commit_csr_o", commit_csr_o, 1'b1);
  expect_bit("commit_ack_o[0]", commit_ack_o[0], 1'b1);
  expect_word("wdata_o[0]", wdata_o[0], csr_rdata_i);
  expect_word("csr_op_o", 32'(csr_op_o), 32'(CSR_RW));
  expect_word("csr_wdata_o", csr_wdata_o, e0.result);
  // csr file fault holds the head and traps with the entry tval
  @(negedge clk_i);
  csr_exception_i.valid     = 1'b1;
  csr_exception_i.cause.num = 32'd2;
  csr_exception_i.tval      = rand_bits(32);
  #1;
  expect_bit("commit_ack_o[0]", commit_ack_o[0], 1'b0);
  expect_bit("exception_o.valid", exception_o.valid, 1'b1);
  expect_word("exception_o.cause", exception_o.cause.num, 32'd2);
  expect_word("exception_o.tval", exception_o.tval, e0.ex.tval);
  // earlier fault from the entry wins
  @(negedge clk_i);
  e0.ex.valid          = 1'b1;
  e0.ex.cause.num      = 32'd12;
  commit_instr0_i      = e0;
  #1;
  expect_bit("commit_ack_o[0]", commit_ack_o[0], 1'b0);
  expect_word("exception_o.cause", exception_o.cause.num, 32'd12);
  expect_word("exception_o.tval", exception_o.tval, e0.ex.tval);
  @(negedge clk_i);
  halt_i = 1'b1;
  #1;
  expect_bit("exception_o.valid", exception_o.valid, 1'b0);
  halt_i = 1'b0;
endtask

task automatic amo_commit();
  @(negedge clk_i);
  commit_instr0_i = make_entry(STORE, AMO_ADD);
  commit_instr1_i = make_entry(ALU, ADD);
  amo_result_i    = rand_bits(32);
  #1;
  expect_word("commit_ack_o", 32'(commit_ack_o), 32'h0);
  expect_bit("we_gpr_o[0]", we_gpr_o[0], 1'b0);
  expect_bit("flush_commit_o", flush_commit_o, 1'b0);
  expect_bit("amo_valid_commit_o", amo_valid_commit_o, 1'b1);
  @(negedge clk_i);
  amo_ack_i = 1'b1;
  #1;
  // head retires alone while port 1 stays blocked
  expect_word("commit_ack_o", 32'(commit_ack_o), 32'h1);
  expect_bit("we_gpr_o[0]", we_gpr_o[0], 1'b1);
  expect_bit("flush_commit_o", flush_commit_o, 1'b1);
  expect_bit("amo_valid_commit_o", amo_valid_commit_o, 1'b1);
  expect_word("wdata_o[0]", wdata_o[0], amo_result_i);
endtask

task automatic fp_writeback();
  scoreboard_entry_t e0;
  scoreboard_entry_t e1;
  e0 = make_entry(FPU, FADD);
  e1 = make_entry(FPU, FADD);
  e0.ex.cause.fp.flags = 5'(rand_bits(5));
  e1.ex.cause.fp.flags = 5'(rand_bits(5));
  @(negedge clk_i);
  commit_instr0_i = e0;
  commit_instr1_i = e1;
  #1;
  expect_word("commit_ack_o", 32'(commit_ack_o), 32'h3);
  expect_word("we_fpr_o", 32'(we_fpr_o), 32'h3);
  expect_word("we_gpr_o", 32'(we_gpr_o), 32'h0);
  expect_word("csr_wdata_o", csr_wdata_o, 32'(e0.ex.cause.fp.flags | e1.ex.cause.fp.flags));
  expect_bit("csr_write_fflags_o", csr_write_fflags_o, 1'b1);
  expect_bit("dirty_fp_state_o", dirty_fp_state_o, 1'b1);
  // fcvt.w goes to the integer file
  @(negedge clk_i);
  commit_instr0_i = make_entry(FPU, FCVT_W);
  #1;
  expect_bit("we_gpr_o[0]", we_gpr_o[0], 1'b1);
  expect_bit("we_fpr_o[0]", we_fpr_o[0], 1'b0);
endtask

/* sim/tb_commit_stage.sv */
/*
 * Testbench for the dual-port commit stage.
 * Drives scoreboard entries on falling edges and checks the combinational
 * responses after a short settle delay.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_commit_stage import commit_pkg::*; ();

  localparam int NUM_TESTS   = 6;
  localparam int WATCHDOG_NS = NUM_TESTS * 40 * 8;

  logic clk_i;
  logic rst_i;

  // DUT inputs
  logic              halt_i;
  logic              single_step_i;
  scoreboard_entry_t commit_instr0_i;
  scoreboard_entry_t commit_instr1_i;
  logic [1:0]        commit_drop_i;
  logic              amo_ack_i;
  logic [XLEN-1:0]   amo_result_i;
  logic [XLEN-1:0]   csr_rdata_i;
  exception_t        csr_exception_i;
  logic              commit_lsu_ready_i;
  logic              no_st_pending_i;

  // DUT outputs
  logic [1:0]                    commit_ack_o;
  logic [1:0][REG_ADDR_BITS-1:0] waddr_o;
  logic [1:0][XLEN-1:0]          wdata_o;
  logic [1:0]                    we_gpr_o;
  logic [1:0]                    we_fpr_o;
  logic [VLEN-1:0]               pc_o;
  logic [TRANS_ID_BITS-1:0]      commit_tran_id_o;
  fu_op_t                        csr_op_o;
  logic [XLEN-1:0]               csr_wdata_o;
  logic                          csr_write_fflags_o;
  logic                          dirty_fp_state_o;
  exception_t                    exception_o;
  logic                          commit_lsu_o;
  logic                          commit_csr_o;
  logic                          amo_valid_commit_o;
  logic                          fence_o;
  logic                          fence_i_o;
  logic                          sfence_vma_o;
  logic                          flush_commit_o;

  // bookkeeping
  int    checks = 0;
  int    errors = 0;
  int    tests_failed = 0;
  int    test_num = 0;
  int    errors_at_start;
  string test_name;
  logic [31:0] lfsr_state = 32'h4922_b5f2;

  commit_stage_top DUT (.*);

  // ------------------------------
  // random source
  // ------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits       = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return bits;
  endfunction

  // valid, fault-free entry with random pc, id, rd and result
  function automatic scoreboard_entry_t make_entry(input fu_t fu, input fu_op_t op);
    scoreboard_entry_t e;
    e          = '0;
    e.pc       = rand_bits(32);
    e.trans_id = 3'(rand_bits(3));
    e.fu       = fu;
    e.op       = op;
    e.rd       = 5'(rand_bits(5));
    e.result   = rand_bits(32);
    e.valid    = 1'b1;
    return e;
  endfunction

  `include "tb_commit_checks.svh"

  // entries invalid and side units idle
  task automatic go_idle();
    @(negedge clk_i);
    commit_instr0_i    = '0;
    commit_instr1_i    = '0;
    commit_drop_i      = '0;
    halt_i             = 1'b0;
    single_step_i      = 1'b0;
    amo_ack_i          = 1'b0;
    csr_exception_i    = '0;
    commit_lsu_ready_i = 1'b0;
    no_st_pending_i    = 1'b0;
  endtask

  task automatic begin_test(input string name);
    test_num++;
    test_name       = name;
    errors_at_start = errors;
    go_idle();
  endtask

  task automatic end_test();
    if (errors == errors_at_start) begin
      $display("test %0d %s: ok", test_num, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", test_num, test_name, errors - errors_at_start);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ------------------------------
  // watchdog
  // ------------------------------
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the test sequence finished");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    rst_i              = 1'b1;
    halt_i             = 1'b0;
    single_step_i      = 1'b0;
    commit_instr0_i    = '0;
    commit_instr1_i    = '0;
    commit_drop_i      = '0;
    amo_ack_i          = 1'b0;
    amo_result_i       = '0;
    csr_rdata_i        = '0;
    csr_exception_i    = '0;
    commit_lsu_ready_i = 1'b0;
    no_st_pending_i    = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    #1;
    // nothing retires with empty entries
    expect_word("commit_ack_o", 32'(commit_ack_o), 32'h0);
    expect_bit("exception_o.valid", exception_o.valid, 1'b0);

    begin_test("dual alu");
    dual_alu_commit();
    end_test();
    begin_test("store");
    store_backpressure();
    end_test();
    begin_test("fences");
    fence_drain();
    end_test();
    begin_test("csr");
    csr_commit_trap();
    end_test();
    begin_test("amo");
    amo_commit();
    end_test();
    begin_test("fp");
    fp_writeback();
    end_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             test_num, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+sim
logic/commit_pkg.sv
logic/commit_grant_if.sv
logic/commit_port0_ctrl.sv
logic/commit_port1_ctrl.sv
logic/commit_csr_path.sv
logic/commit_exception_sel.sv
logic/commit_stage_top.sv
sim/tb_commit_stage.sv
